/* build.f */
src/backend_pkg.sv
src/backend_if.sv
src/alu.sv
src/data_scratch.sv
src/reg_file.sv
src/issue_decode.sv
src/exec_pipe.sv
src/backend_top.sv
verification/tb_clock_gen.sv
verification/exec_pipe_properties.sv
verification/tb_backend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module tb_backend > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "compile failed"
	exit 1
fi

./obj_dir/Vtb_backend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" sim.log; then
	exit 1
fi
exit 0

/* verification/tb_backend.sv */
`timescale 1ns/1ns

module tb_backend;
	import backend_pkg::*;

	localparam int NUM_DIRECTED = 15;
	localparam int NUM_RANDOM   = 400;
	localparam int CYCLE_LIMIT  = 16 + (NUM_DIRECTED + NUM_RANDOM) * 3 + 50;

	logic              clk;
	logic              rst_n;
	logic              inst_valid;
	logic [XLEN-1:0]   inst;
	logic              stall;
	logic              wb_valid;
	logic [REG_AW-1:0] wb_addr;
	logic [XLEN-1:0]   wb_data;

	logic [31:0]       lfsr = 32'h2dfc31c5;
	int                cycle = 0;

	// architectural model
	logic [XLEN-1:0]   model_regs [32];
	logic [XLEN-1:0]   model_mem [64];
	logic              written [64];
	logic [5:0]        last_store_w = '0;

	// the two most recent loads and their accept edges
	logic [REG_AW-1:0] load_rd [$];
	int                load_edge [$];

	// expected writebacks in program order
	logic [REG_AW-1:0] exp_addr [$];
	logic [XLEN-1:0]   exp_data [$];
	int                exp_cycle [$];
	string             exp_name [$];

	logic [REG_AW-1:0] e_addr;
	logic [XLEN-1:0]   e_data;
	int                e_cycle;
	string             e_name;

	int mismatch_errs   = 0;
	int unexpected_errs = 0;
	int late_errs       = 0;
	int missing_errs    = 0;
	int hung_errs       = 0;

	tb_clock_gen i_tb_clock_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	backend_top i_backend_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.inst_valid_i (inst_valid),
		.inst_i       (inst),
		.stall_o      (stall),
		.wb_valid_o   (wb_valid),
		.wb_addr_o    (wb_addr),
		.wb_data_o    (wb_data)
	);

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return v;
	endfunction

	function automatic logic [XLEN-1:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
		input logic [4:0] rj, input logic [4:0] rd);
		inst_word_u iw;
		iw.r3.opcode = op;
		iw.r3.rk     = rk;
		iw.r3.rj     = rj;
		iw.r3.rd     = rd;
		return iw;
	endfunction

	function automatic logic [XLEN-1:0] enc_ri12(input logic [9:0] op, input logic [11:0] si12,
		input logic [4:0] rj, input logic [4:0] rd);
		inst_word_u iw;
		iw.ri12.opcode = op;
		iw.ri12.si12   = si12;
		iw.ri12.rj     = rj;
		iw.ri12.rd     = rd;
		return iw;
	endfunction

	// executes one instruction on the model, returns 1 when it writes a register
	function automatic logic ref_exec(input logic [XLEN-1:0] word,
		output logic [REG_AW-1:0] waddr, output logic [XLEN-1:0] wdata);
		inst_word_u      iw;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] addr;
		logic            wr;
		iw    = word;
		a     = model_regs[iw.r3.rj];
		b     = model_regs[iw.r3.rk];
		imm   = {{20{iw.ri12.si12[11]}}, iw.ri12.si12};
		addr  = a + imm;
		waddr = iw.r3.rd;
		wdata = '0;
		wr    = 1'b1;
		case (iw.r3.opcode)
			OP_ADD_W: wdata = a + b;
			OP_SUB_W: wdata = a - b;
			OP_AND:   wdata = a & b;
			OP_OR:    wdata = a | b;
			OP_XOR:   wdata = a ^ b;
			OP_SLT:   wdata = {31'b0, $signed(a) < $signed(b)};
			default: begin
				case (iw.ri12.opcode)
					OP_ADDI_W: wdata = addr;
					OP_LD_W:   wdata = model_mem[addr[7:2]];
					OP_ST_W: begin
						model_mem[addr[7:2]] = model_regs[iw.ri12.rd];
						written[addr[7:2]]   = 1'b1;
						last_store_w         = addr[7:2];
						wr                   = 1'b0;
					end
					default:   wr = 1'b0;
				endcase
			end
		endcase
		if (waddr == '0)
			wr = 1'b0; // r0 never written
		if (wr)
			model_regs[waddr] = wdata;
		return wr;
	endfunction

	// load-use rule: a source matches the rd of a load in EX or M1
	function automatic logic stall_due(input logic [XLEN-1:0] word);
		inst_word_u        iw;
		logic [REG_AW-1:0] src2;
		logic              use2;
		logic              hit;
		iw  = word;
		hit = 1'b0;
		case (iw.r3.opcode)
			OP_ADD_W, OP_SUB_W, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
				src2 = iw.r3.rk;
				use2 = 1'b1;
			end
			default: begin
				src2 = iw.ri12.rd;
				use2 = iw.ri12.opcode == OP_ST_W;
				if (!use2 && iw.ri12.opcode != OP_ADDI_W && iw.ri12.opcode != OP_LD_W)
					return 1'b0; // unknown encoding never stalls
			end
		endcase
		foreach (load_rd[k])
			if (load_edge[k] >= cycle - 1 && load_rd[k] != '0 &&
				(load_rd[k] == iw.r3.rj || (use2 && load_rd[k] == src2)))
				hit = 1'b1;
		return hit;
	endfunction

	task automatic check_stall(input logic [XLEN-1:0] word, input string name);
		logic exp_stall;
		exp_stall = stall_due(word);
		if (stall !== exp_stall) begin
			$display("Mismatch %s stall_o expected %b actual %b", name, exp_stall, stall);
			mismatch_errs++;
		end
	endtask

	function automatic logic [XLEN-1:0] random_inst();
		logic [3:0]        kind;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rj;
		logic [REG_AW-1:0] rk;
		logic [5:0]        w;
		logic [11:0]       mem_off;
		logic [XLEN-1:0]   word;
		kind = 4'(rand_bits(4));
		rd   = 5'(rand_bits(3)); // r0..r7 only, lots of hazards
		rj   = 5'(rand_bits(3));
		rk   = 5'(rand_bits(3));
		w    = 6'(rand_bits(6));
		if (rand_bits(1) != 0)
			w = last_store_w; // often hit the word just stored
		mem_off = {4'b0, w, 2'b00};
		case (kind)
			4'd0, 4'd1:   word = enc_3r(OP_ADD_W, rk, rj, rd);
			4'd2:         word = enc_3r(OP_SUB_W, rk, rj, rd);
			4'd3:         word = enc_3r(OP_AND, rk, rj, rd);
			4'd4:         word = enc_3r(OP_OR, rk, rj, rd);
			4'd5:         word = enc_3r(OP_XOR, rk, rj, rd);
			4'd6:         word = enc_3r(OP_SLT, rk, rj, rd);
			4'd10, 4'd11: begin
				if (written[w])
					word = enc_ri12(OP_LD_W, mem_off, 5'd0, rd);
				else
					word = enc_ri12(OP_ST_W, mem_off, 5'd0, rd); // never load unwritten words
			end
			4'd12, 4'd13: word = enc_ri12(OP_ST_W, mem_off, 5'd0, rd);
			4'd14:        word = {10'h3ff, 22'(rand_bits(22))}; // no such opcode
			default:      word = enc_ri12(OP_ADDI_W, 12'(rand_bits(12)), rj, rd);
		endcase
		return word;
	endfunction

	task automatic issue_inst(input logic [XLEN-1:0] word, input string name);
		logic              has_wb;
		logic [REG_AW-1:0] waddr;
		logic [XLEN-1:0]   wdata;
		@(negedge clk);
		inst_valid = 1'b1;
		inst       = word;
		#1;
		check_stall(word, name);
		while (stall) begin // hold until the load clears
			@(negedge clk);
			#1;
			check_stall(word, name);
		end
		has_wb = ref_exec(word, waddr, wdata);
		if (has_wb) begin
			exp_addr.push_back(waddr);
			exp_data.push_back(wdata);
			exp_cycle.push_back(cycle + 4); // accept edge plus three
			exp_name.push_back(name);
		end
		if (word[31:22] == OP_LD_W) begin
			load_rd.push_back(word[4:0]);
			load_edge.push_back(cycle + 1);
			if (load_rd.size() > 2) begin
				load_rd.delete(0);
				load_edge.delete(0);
			end
		end
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		inst_valid = 1'b0;
	endtask

	task automatic run_directed();
		issue_inst(enc_ri12(OP_ADDI_W, 12'd5, 5'd0, 5'd1), "alu_forwarding");
		issue_inst(enc_ri12(OP_ADDI_W, 12'hffd, 5'd0, 5'd2), "alu_forwarding");
		issue_inst(enc_3r(OP_ADD_W, 5'd2, 5'd1, 5'd3), "alu_forwarding");
		issue_inst(enc_3r(OP_SUB_W, 5'd1, 5'd3, 5'd4), "alu_forwarding");
		issue_inst(enc_3r(OP_SLT, 5'd3, 5'd4, 5'd5), "alu_forwarding");
		issue_inst(enc_3r(OP_XOR, 5'd1, 5'd5, 5'd6), "alu_forwarding");
		issue_inst(enc_ri12(OP_ST_W, 12'd8, 5'd0, 5'd6), "load_store");
		issue_inst(enc_ri12(OP_LD_W, 12'd8, 5'd0, 5'd7), "load_store");
		issue_inst(enc_3r(OP_ADD_W, 5'd7, 5'd7, 5'd1), "load_use");
		issue_inst(enc_ri12(OP_LD_W, 12'd8, 5'd0, 5'd2), "load_use");
		issue_inst(enc_ri12(OP_ADDI_W, 12'd1, 5'd0, 5'd5), "load_use");
		issue_inst(enc_3r(OP_OR, 5'd1, 5'd2, 5'd3), "load_use"); // one stall cycle
		issue_inst(enc_ri12(OP_ADDI_W, 12'd7, 5'd0, 5'd0), "no_dest");
		issue_inst(32'hffc00000, "no_dest");
		issue_inst(enc_3r(OP_OR, 5'd3, 5'd0, 5'd4), "no_dest");
	endtask

	task automatic print_counts();
		$display("errors: mismatch %0d, unexpected %0d, late %0d, missing %0d, hung %0d",
			mismatch_errs, unexpected_errs, late_errs, missing_errs, hung_errs);
	endtask

	// cycle count and run limit
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("hung pipeline: run did not finish within %0d cycles", CYCLE_LIMIT);
			hung_errs = hung_errs + 1;
			print_counts();
			$display("Finished with errors");
			$finish;
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			if (exp_addr.size() == 0) begin
				$display("unexpected writeback to r%0d with data %h in cycle %0d",
					wb_addr, wb_data, cycle);
				unexpected_errs++;
			end else begin
				e_addr  = exp_addr.pop_front();
				e_data  = exp_data.pop_front();
				e_cycle = exp_cycle.pop_front();
				e_name  = exp_name.pop_front();
				if (wb_addr !== e_addr) begin
					$display("Mismatch %s wb_addr expected %0d actual %0d", e_name, e_addr, wb_addr);
					mismatch_errs++;
				end
				if (wb_data !== e_data) begin
					$display("Mismatch %s wb_data expected %h actual %h", e_name, e_data, wb_data);
					mismatch_errs++;
				end
				if (cycle != e_cycle) begin
					$display("late writeback in %s: due in cycle %0d, seen in cycle %0d",
						e_name, e_cycle, cycle);
					late_errs++;
				end
			end
		end
	end

	initial begin
		inst_valid = 1'b0;
		inst       = '0;
		foreach (model_regs[k])
			model_regs[k] = '0;
		foreach (written[k])
			written[k] = 1'b0;
		wait (rst_n === 1'b1);
		run_directed();
		for (int i = 0; i < NUM_RANDOM; i++) begin
			if (rand_bits(3) == 0)
				idle_cycle();
			issue_inst(random_inst(), "random");
		end
		idle_cycle();
		// drain, bounded well past the 4 cycle latency
		for (int k = 0; k < 12 && exp_addr.size() != 0; k++)
			@(posedge clk);
		repeat (4) @(posedge clk); // room for stray pulses
		foreach (exp_addr[k])
			$display("missing writeback for %s: r%0d data %h", exp_name[k], exp_addr[k], exp_data[k]);
		missing_errs = exp_addr.size();
		print_counts();
		if (mismatch_errs + unexpected_errs + late_errs + missing_errs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* verification/exec_pipe_properties.sv */
`timescale 1ns/1ns

module exec_pipe_properties (
	input logic                           clk_i,
	input logic                           rst_n_i,
	input logic                           issue_valid_i,
	input logic [backend_pkg::REG_AW-1:0] issue_rd_i,
	input logic                           ld_in_flight_i, // load in EX or M1
	input logic                           wb_valid_i
);

	logic held;

	// a load-use stall always looks like this, an idle slot behind a load may too
	assign held = !issue_valid_i && ld_in_flight_i;

	no_wb_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !wb_valid_i)
		else $error("writeback pulse while reset is asserted");

	// the pulse belongs to the slot taken into EX four edges earlier
	no_wb_to_r0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_valid_i |-> $past(issue_valid_i, 4) && $past(issue_rd_i, 4) != '0)
		else $error("writeback pulse for a slot with destination r0");

	// three held cycles in a row would mean a stall longer than 2
	stall_bounded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		held && $past(held) |-> !$past(held, 2))
		else $error("load-use stall lasted longer than 2 cycles");

endmodule

bind exec_pipe exec_pipe_properties i_exec_pipe_properties (
	.clk_i          (clk),
	.rst_n_i        (rst_n),
	.issue_valid_i  (issue.valid),
	.issue_rd_i     (issue.rd),
	.ld_in_flight_i ((ex_valid && ex_mem_op == backend_pkg::MEM_LOAD) ||
		(m1_valid && m1_mem_op == backend_pkg::MEM_LOAD)),
	.wb_valid_i     (wb_valid_o)
);

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o; // 4 ns period
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (16) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

/* src/backend_top.sv */
`timescale 1ns/1ns

module backend_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           inst_valid_i,
	input  logic [backend_pkg::XLEN-1:0]   inst_i,
	output logic                           stall_o,
	output logic                           wb_valid_o,
	output logic [backend_pkg::REG_AW-1:0] wb_addr_o,
	output logic [backend_pkg::XLEN-1:0]   wb_data_o
);
	import backend_pkg::*;

	logic [REG_AW-1:0] rs1_addr;
	logic [REG_AW-1:0] rs2_addr;
	logic [XLEN-1:0]   rs1_data;
	logic [XLEN-1:0]   rs2_data;

	issue_if issue_bus ();
	fwd_if   fwd_bus ();

	issue_decode i_issue_decode (
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.stall_o      (stall_o),
		.rs1_addr_o   (rs1_addr),
		.rs2_addr_o   (rs2_addr),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.issue        (issue_bus.producer),
		.fwd          (fwd_bus.consumer)
	);

	exec_pipe i_exec_pipe (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue_bus.consumer),
		.fwd        (fwd_bus.producer),
		.wb_valid_o (wb_valid_o),
		.wb_addr_o  (wb_addr_o),
		.wb_data_o  (wb_data_o)
	);

	// write port fed straight from the WB stage
	reg_file i_reg_file (
		.clk        (clk),
		.rst_n      (rst_n),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.we_i       (wb_valid_o),
		.waddr_i    (wb_addr_o),
		.wdata_i    (wb_data_o)
	);

endmodule

/* src/exec_pipe.sv */
`timescale 1ns/1ns

module exec_pipe (
	input  logic                           clk,
	input  logic                           rst_n,
	issue_if.consumer                      issue,
	fwd_if.producer                        fwd,
	output logic                           wb_valid_o,
	output logic [backend_pkg::REG_AW-1:0] wb_addr_o,
	output logic [backend_pkg::XLEN-1:0]   wb_data_o
);
	import backend_pkg::*;

	logic              ex_valid;
	alu_op_e           ex_alu_op;
	mem_op_e           ex_mem_op;
	logic              ex_use_imm;
	logic [REG_AW-1:0] ex_rd;
	logic [XLEN-1:0]   ex_op_a;
	logic [XLEN-1:0]   ex_op_b;
	logic [XLEN-1:0]   ex_store_data;
	logic [XLEN-1:0]   alu_b;
	logic [XLEN-1:0]   alu_result;

	logic              m1_valid;
	mem_op_e           m1_mem_op;
	logic [REG_AW-1:0] m1_rd;
	logic [XLEN-1:0]   m1_result; // byte address for ld/st
	logic [XLEN-1:0]   m1_store_data;

	logic              m2_valid;
	mem_op_e           m2_mem_op;
	logic [REG_AW-1:0] m2_rd;
	logic [XLEN-1:0]   m2_result;
	logic [XLEN-1:0]   m2_final;
	logic [XLEN-1:0]   scratch_rdata;

	logic              wb_valid;
	logic              wb_store;
	logic [REG_AW-1:0] wb_rd;
	logic [XLEN-1:0]   wb_data;

	// stage valids
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			m1_valid <= 1'b0;
			m2_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			ex_valid <= issue.valid;
			m1_valid <= ex_valid;
			m2_valid <= m1_valid;
			wb_valid <= m2_valid;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu_op     <= issue.alu_op;
		ex_mem_op     <= issue.mem_op;
		ex_use_imm    <= issue.use_imm;
		ex_rd         <= issue.rd;
		ex_op_a       <= issue.op_a;
		ex_op_b       <= issue.op_b;
		ex_store_data <= issue.store_data;

		m1_mem_op     <= ex_mem_op;
		m1_rd         <= ex_rd;
		m1_result     <= alu_result;
		m1_store_data <= ex_store_data;

		m2_mem_op     <= m1_mem_op;
		m2_rd         <= m1_rd;
		m2_result     <= m1_result;

		wb_store      <= m2_mem_op == MEM_STORE;
		wb_rd         <= m2_rd;
		wb_data       <= m2_final; // load data captured here
	end

	assign alu_b = ex_use_imm ? ex_op_b : ex_store_data;

	alu i_alu (
		.op_i     (ex_alu_op),
		.a_i      (ex_op_a),
		.b_i      (alu_b),
		.result_o (alu_result)
	);

	// word address taken in M1, registered inside the scratchpad
	data_scratch i_data_scratch (
		.clk       (clk),
		.addr_i    (m1_result[SCRATCH_AW+1:2]),
		.wr_en_i   (m1_valid && m1_mem_op == MEM_STORE),
		.wr_data_i (m1_store_data),
		.rd_data_o (scratch_rdata)
	);

	assign m2_final = (m2_mem_op == MEM_LOAD) ? scratch_rdata : m2_result;

	assign fwd.ex_valid  = ex_valid && ex_mem_op != MEM_STORE;
	assign fwd.ex_load   = ex_mem_op == MEM_LOAD;
	assign fwd.ex_rd     = ex_rd;
	assign fwd.ex_result = alu_result;
	assign fwd.m1_valid  = m1_valid && m1_mem_op != MEM_STORE;
	assign fwd.m1_load   = m1_mem_op == MEM_LOAD;
	assign fwd.m1_rd     = m1_rd;
	assign fwd.m1_result = m1_result;
	assign fwd.m2_valid  = m2_valid && m2_mem_op != MEM_STORE;
	assign fwd.m2_rd     = m2_rd;
	assign fwd.m2_result = m2_final;

	assign wb_valid_o = wb_valid && !wb_store && wb_rd != '0;
	assign wb_addr_o  = wb_rd;
	assign wb_data_o  = wb_data;

endmodule

/* src/issue_decode.sv */
`timescale 1ns/1ns

module issue_decode (
	input  logic                             inst_valid_i,
	input  logic [backend_pkg::XLEN-1:0]     inst_i,
	output logic                             stall_o,
	output logic [backend_pkg::REG_AW-1:0]   rs1_addr_o,
	output logic [backend_pkg::REG_AW-1:0]   rs2_addr_o,
	input  logic [backend_pkg::XLEN-1:0]     rs1_data_i,
	input  logic [backend_pkg::XLEN-1:0]     rs2_data_i,
	issue_if.producer                        issue,
	fwd_if.consumer                          fwd
);
	import backend_pkg::*;

	inst_word_u inst;
	alu_op_e    alu_op;
	mem_op_e    mem_op;
	logic       use_imm;
	logic       is_3r;
	logic       known;
	logic       use_rs2;

	// newest producer wins, loads in EX/M1 have no data yet
	function automatic logic [XLEN-1:0] pick_operand(input logic [REG_AW-1:0] addr,
		input logic [XLEN-1:0] rf_data);
		if (addr == '0)
			return '0;
		if (fwd.ex_valid && !fwd.ex_load && fwd.ex_rd == addr)
			return fwd.ex_result;
		if (fwd.m1_valid && !fwd.m1_load && fwd.m1_rd == addr)
			return fwd.m1_result;
		if (fwd.m2_valid && fwd.m2_rd == addr)
			return fwd.m2_result;
		return rf_data;
	endfunction

	function automatic logic load_pending(input logic [REG_AW-1:0] addr);
		if (addr == '0)
			return 1'b0;
		return (fwd.ex_valid && fwd.ex_load && fwd.ex_rd == addr) ||
			(fwd.m1_valid && fwd.m1_load && fwd.m1_rd == addr);
	endfunction

	assign inst = inst_i;

	always_comb begin
		alu_op  = ALU_ADD; // also the AGU add for ld/st
		mem_op  = MEM_NONE;
		use_imm = 1'b0;
		is_3r   = 1'b1;
		known   = 1'b1;
		case (inst.r3.opcode)
			OP_ADD_W: alu_op = ALU_ADD;
			OP_SUB_W: alu_op = ALU_SUB;
			OP_AND:   alu_op = ALU_AND;
			OP_OR:    alu_op = ALU_OR;
			OP_XOR:   alu_op = ALU_XOR;
			OP_SLT:   alu_op = ALU_SLT;
			default:  is_3r = 1'b0;
		endcase
		if (!is_3r) begin
			use_imm = 1'b1;
			case (inst.ri12.opcode)
				OP_ADDI_W: mem_op = MEM_NONE;
				OP_LD_W:   mem_op = MEM_LOAD;
				OP_ST_W:   mem_op = MEM_STORE;
				default:   known = 1'b0; // bubble
			endcase
		end
	end

	assign use_rs2    = is_3r || mem_op == MEM_STORE;
	assign rs1_addr_o = inst.r3.rj;
	assign rs2_addr_o = is_3r ? inst.r3.rk : inst.r3.rd; // st.w reads its data from rd

	assign stall_o = inst_valid_i && known &&
		(load_pending(rs1_addr_o) || (use_rs2 && load_pending(rs2_addr_o)));

	assign issue.valid      = inst_valid_i && known && !stall_o;
	assign issue.alu_op     = alu_op;
	assign issue.mem_op     = mem_op;
	assign issue.use_imm    = use_imm;
	assign issue.rd         = inst.r3.rd;
	assign issue.op_a       = pick_operand(rs1_addr_o, rs1_data_i);
	assign issue.op_b       = {{(XLEN-12){inst.ri12.si12[11]}}, inst.ri12.si12};
	assign issue.store_data = pick_operand(rs2_addr_o, rs2_data_i);

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [backend_pkg::REG_AW-1:0] rs1_addr_i,
	input  logic [backend_pkg::REG_AW-1:0] rs2_addr_i,
	output logic [backend_pkg::XLEN-1:0]   rs1_data_o,
	output logic [backend_pkg::XLEN-1:0]   rs2_data_o,
	input  logic                           we_i,
	input  logic [backend_pkg::REG_AW-1:0] waddr_i,
	input  logic [backend_pkg::XLEN-1:0]   wdata_i
);
	import backend_pkg::*;

	logic [(1<<REG_AW)-1:1][XLEN-1:0] regs; // no storage for r0

	// write-through so a reader in the WB cycle sees the new value
	function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
		if (addr == '0)
			return '0;
		if (we_i && waddr_i == addr)
			return wdata_i;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n)
			regs <= '0;
		else if (we_i && waddr_i != '0)
			regs[waddr_i] <= wdata_i;
	end

	assign rs1_data_o = read_port(rs1_addr_i);
	assign rs2_data_o = read_port(rs2_addr_i);

endmodule

/* src/data_scratch.sv */
`timescale 1ns/1ns

module data_scratch (
	input  logic                               clk,
	input  logic [backend_pkg::SCRATCH_AW-1:0] addr_i,
	input  logic                               wr_en_i,
	input  logic [backend_pkg::XLEN-1:0]       wr_data_i,
	output logic [backend_pkg::XLEN-1:0]       rd_data_o
);
	import backend_pkg::*;

	logic [XLEN-1:0]       mem [0:(1<<SCRATCH_AW)-1];
	logic [SCRATCH_AW-1:0] addr_q;
	logic                  wr_en_q;
	logic [XLEN-1:0]       wr_data_q;

	// M1/M2 boundary
	always_ff @(posedge clk) begin
		addr_q    <= addr_i;
		wr_en_q   <= wr_en_i;
		wr_data_q <= wr_data_i;
	end

	// store completes at the end of M2
	always_ff @(posedge clk) begin
		if (wr_en_q)
			mem[addr_q] <= wr_data_q;
	end

	assign rd_data_o = mem[addr_q]; // read during M2

endmodule

/* src/alu.sv */
`timescale 1ns/1ns

module alu (
	input  backend_pkg::alu_op_e         op_i,
	input  logic [backend_pkg::XLEN-1:0] a_i,
	input  logic [backend_pkg::XLEN-1:0] b_i,
	output logic [backend_pkg::XLEN-1:0] result_o
);
	import backend_pkg::*;

	logic less_than;

	assign less_than = $signed(a_i) < $signed(b_i);

	always_comb begin
		case (op_i)
			ALU_ADD: result_o = a_i + b_i;
			ALU_SUB: result_o = a_i - b_i;
			ALU_AND: result_o = a_i & b_i;
			ALU_OR:  result_o = a_i | b_i;
			ALU_XOR: result_o = a_i ^ b_i;
			ALU_SLT: result_o = {{(XLEN-1){1'b0}}, less_than}; // 1 or 0
			default: result_o = a_i + b_i;
		endcase
	end

endmodule

/* src/backend_if.sv */
`timescale 1ns/1ns

// decoded slot from issue into EX
interface issue_if;
	import backend_pkg::*;

	logic              valid;
	alu_op_e           alu_op;
	mem_op_e           mem_op;
	logic              use_imm;    // operand b is the immediate
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   op_a;
	logic [XLEN-1:0]   op_b;       // sign extended si12
	logic [XLEN-1:0]   store_data; // second register operand

	modport producer (output valid, alu_op, mem_op, use_imm, rd, op_a, op_b, store_data);
	modport consumer (input valid, alu_op, mem_op, use_imm, rd, op_a, op_b, store_data);
endinterface

// in-flight destinations and results back to issue
interface fwd_if;
	import backend_pkg::*;

	logic              ex_valid;  // valid and writes rd
	logic              ex_load;
	logic [REG_AW-1:0] ex_rd;
	logic [XLEN-1:0]   ex_result;
	logic              m1_valid;
	logic              m1_load;
	logic [REG_AW-1:0] m1_rd;
	logic [XLEN-1:0]   m1_result;
	logic              m2_valid;
	logic [REG_AW-1:0] m2_rd;
	logic [XLEN-1:0]   m2_result; // load data already merged in

	modport producer (output ex_valid, ex_load, ex_rd, ex_result, m1_valid, m1_load, m1_rd,
		m1_result, m2_valid, m2_rd, m2_result);
	modport consumer (input ex_valid, ex_load, ex_rd, ex_result, m1_valid, m1_load, m1_rd,
		m1_result, m2_valid, m2_rd, m2_result);
endinterface

/* src/backend_pkg.sv */
package backend_pkg;

	localparam int XLEN       = 32;
	localparam int REG_AW     = 5;
	localparam int SCRATCH_AW = 6; // 64 words, byte address bits 7:2

	// 3R format opcodes, inst[31:15]
	localparam logic [16:0] OP_ADD_W = 17'h00020;
	localparam logic [16:0] OP_SUB_W = 17'h00022;
	localparam logic [16:0] OP_SLT   = 17'h00024;
	localparam logic [16:0] OP_AND   = 17'h00029;
	localparam logic [16:0] OP_OR    = 17'h0002a;
	localparam logic [16:0] OP_XOR   = 17'h0002b;

	// 2RI12 format opcodes, inst[31:22]
	localparam logic [9:0] OP_ADDI_W = 10'h00a;
	localparam logic [9:0] OP_LD_W   = 10'h0a2;
	localparam logic [9:0] OP_ST_W   = 10'h0a6;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_e;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_e;

	// one instruction word, two field layouts
	typedef union packed {
		struct packed {
			logic [16:0] opcode;
			logic [4:0]  rk;
			logic [4:0]  rj;
			logic [4:0]  rd;
		} r3;
		struct packed {
			logic [9:0]  opcode;
			logic [11:0] si12;
			logic [4:0]  rj;
			logic [4:0]  rd;
		} ri12;
	} inst_word_u;

endpackage
